// File: Bender.yml
package:
  name: icache

export_include_dirs:
  - .

sources:
  - icache_addr_pkg.sv
  - icache_ctrl_pkg.sv
  - icache_way.sv
  - icache_way_select.sv
  - icache_controller.sv
  - icache_top.sv
  - target: test
    files:
      - tb_icache_asserts.sv
      - tb_icache.sv

// File: flist.f
+incdir+.
icache_addr_pkg.sv
icache_ctrl_pkg.sv
icache_way.sv
icache_way_select.sv
icache_controller.sv
icache_top.sv
tb_icache_asserts.sv
tb_icache.sv

// File: icache_addr_pkg.sv
////////////////////////////////////////////////////////////
// Address and line format of the instruction cache
// Field widths come from the sizing macros
////////////////////////////////////////////////////////////
`default_nettype none

`include "icache_macros.svh"

package icache_addr_pkg;

   // Tag compared against the stored tag of each way
   typedef logic [`ICACHE_TAG_W-1:0]     tag_t;

   // Set index, also the flush counter
   typedef logic [`ICACHE_SET_W-1:0]     set_idx_t;

   // One cache line, same width as the fetch data
   typedef logic [`ICACHE_LINE_W-1:0]    line_t;

   // One bit per way
   typedef logic [`ICACHE_NB_WAYS-1:0]   way_oh_t;

   // Fetch address split into its fields
   typedef struct packed
   {
      tag_t                          tag;
      set_idx_t                      set;
      logic [`ICACHE_OFFSET_W-1:0]   offset;   // Byte within the line
   } fetch_addr_t;

endpackage

`default_nettype wire

// File: icache_controller.sv
////////////////////////////////////////////////////////////
// Cache controller: bypass, flush, lookup and refill
// Refill port is single beat, one refill outstanding at most
// Leaving bypass waits for the last bypassed refill to return
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module icache_controller
(
   input  wire logic                        clk,
   input  wire logic                        rst_n,

   input  wire logic                        bypass_i,
   input  wire logic                        flush_i,
   output logic                             bypassed_o,
   output logic                             flushed_o,

   // Fetch port
   input  wire logic                        fetch_req_i,
   input  wire logic [`ICACHE_ADDR_W-1:0]   fetch_addr_i,
   output logic                             fetch_gnt_o,
   output logic                             fetch_rvalid_o,
   output logic [`ICACHE_LINE_W-1:0]        fetch_rdata_o,

   // Refill port
   output logic                             refill_req_o,
   output logic [`ICACHE_ADDR_W-1:0]        refill_addr_o,
   input  wire logic                        refill_gnt_i,
   input  wire logic                        refill_rvalid_i,
   input  wire logic [`ICACHE_LINE_W-1:0]   refill_rdata_i,

   output icache_ctrl_pkg::way_cmd_t        way_cmd_o,
   input  wire icache_ctrl_pkg::lookup_t    lookup_i
);

   localparam icache_addr_pkg::set_idx_t SET_LAST =
      icache_addr_pkg::set_idx_t'(`ICACHE_NB_SETS - 1);

   icache_ctrl_pkg::ctrl_state_e  state_q, state_d;
   icache_addr_pkg::fetch_addr_t  fetch_addr;
   icache_addr_pkg::fetch_addr_t  addr_q;        // Address of the fetch in flight
   icache_addr_pkg::set_idx_t     flush_cnt_q;
   icache_addr_pkg::way_oh_t      victim_q;
   logic                          bypass_pend_q; // Bypassed refill not yet returned
   logic                          save_victim;
   logic                          lookup_hit;

   assign fetch_addr    = fetch_addr_i;
   assign refill_addr_o = addr_q;
   assign lookup_hit    = lookup_i.done & lookup_i.hit;
   assign bypassed_o    = (state_q == icache_ctrl_pkg::DISABLED) ||
                          (state_q == icache_ctrl_pkg::BYPASS_DELAY);

   ////////////////////////////////////////////////////////////
   // Registers
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk, negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q       <= icache_ctrl_pkg::DISABLED;
         flush_cnt_q   <= '0;
         victim_q      <= '0;
         bypass_pend_q <= 1'b0;
      end
      else
      begin
         state_q <= state_d;
         if (state_q == icache_ctrl_pkg::FLUSH)
            flush_cnt_q <= flush_cnt_q + 1'b1;   // Wraps back to 0 at the end
         if (save_victim)
            victim_q <= lookup_i.victim;
         if (bypassed_o && fetch_gnt_o)
            bypass_pend_q <= 1'b1;
         else if (refill_rvalid_i)
            bypass_pend_q <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (fetch_gnt_o)
         addr_q <= fetch_addr;
   end

   ////////////////////////////////////////////////////////////
   // Next state, port outputs and way command
   ////////////////////////////////////////////////////////////
   always_comb
   begin
      state_d          = state_q;
      fetch_gnt_o      = 1'b0;
      fetch_rvalid_o   = 1'b0;
      fetch_rdata_o    = refill_rdata_i;
      refill_req_o     = 1'b0;
      flushed_o        = 1'b0;
      save_victim      = 1'b0;

      way_cmd_o.rd     = 1'b0;
      way_cmd_o.wr     = 1'b0;
      way_cmd_o.inv    = 1'b0;
      way_cmd_o.wr_sel = victim_q;
      way_cmd_o.set    = fetch_addr.set;
      way_cmd_o.tag    = fetch_addr.tag;
      way_cmd_o.wdata  = refill_rdata_i;

      unique case (state_q)
         icache_ctrl_pkg::DISABLED:
         begin
            fetch_rvalid_o = refill_rvalid_i;   // Pass through
            if (bypass_i)
            begin
               // Next grant only once the previous refill is back
               fetch_gnt_o = fetch_req_i & (~bypass_pend_q | refill_rvalid_i);
               if (fetch_gnt_o)
                  state_d = icache_ctrl_pkg::BYPASS_DELAY;
            end
            else if (!bypass_pend_q)
               state_d = icache_ctrl_pkg::FLUSH;
         end

         icache_ctrl_pkg::BYPASS_DELAY:
         begin
            fetch_rvalid_o = refill_rvalid_i;
            refill_req_o   = 1'b1;
            if (refill_gnt_i)
               state_d = icache_ctrl_pkg::DISABLED;
         end

         icache_ctrl_pkg::FLUSH:
         begin
            way_cmd_o.inv = 1'b1;
            way_cmd_o.set = flush_cnt_q;
            if (flush_cnt_q == SET_LAST)
            begin
               flushed_o = 1'b1;
               state_d   = icache_ctrl_pkg::IDLE;
            end
         end

         icache_ctrl_pkg::IDLE:
         begin
            if (bypass_i)
               state_d = icache_ctrl_pkg::DISABLED;
            else if (flush_i)
               state_d = icache_ctrl_pkg::FLUSH;
            else
            begin
               fetch_gnt_o  = fetch_req_i;
               way_cmd_o.rd = fetch_req_i;
               if (fetch_req_i)
                  state_d = icache_ctrl_pkg::LOOKUP;
            end
         end

         icache_ctrl_pkg::LOOKUP:
         begin
            if (lookup_hit)
            begin
               fetch_rvalid_o = 1'b1;
               fetch_rdata_o  = lookup_i.hit_line;
               // Pipelined grant, bypass and flush are handled in IDLE
               fetch_gnt_o    = fetch_req_i & ~(bypass_i | flush_i);
               way_cmd_o.rd   = fetch_gnt_o;
               state_d        = fetch_gnt_o ? icache_ctrl_pkg::LOOKUP
                                            : icache_ctrl_pkg::IDLE;
            end
            else
            begin
               refill_req_o = 1'b1;
               save_victim  = 1'b1;
               state_d      = refill_gnt_i ? icache_ctrl_pkg::WAIT_REFILL_DONE
                                           : icache_ctrl_pkg::WAIT_REFILL_GNT;
            end
         end

         icache_ctrl_pkg::WAIT_REFILL_GNT:
         begin
            refill_req_o = 1'b1;
            if (refill_gnt_i)
               state_d = icache_ctrl_pkg::WAIT_REFILL_DONE;
         end

         icache_ctrl_pkg::WAIT_REFILL_DONE:
         begin
            fetch_rvalid_o = refill_rvalid_i;
            way_cmd_o.wr   = refill_rvalid_i;   // Fill victim while returning data
            way_cmd_o.set  = addr_q.set;
            way_cmd_o.tag  = addr_q.tag;
            if (refill_rvalid_i)
               state_d = icache_ctrl_pkg::IDLE;
         end

         default:
         begin
            state_d = icache_ctrl_pkg::DISABLED;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: icache_ctrl_pkg.sv
////////////////////////////////////////////////////////////
// Controller states and the buses between the controller,
// the ways and the way selector
////////////////////////////////////////////////////////////
`default_nettype none

package icache_ctrl_pkg;

   typedef enum logic [2:0]
   {
      DISABLED,            // Bypass, fetches go to the refill port
      BYPASS_DELAY,        // Bypassed refill request in flight
      FLUSH,               // Invalidate one set per cycle
      IDLE,
      LOOKUP,              // Way responses valid
      WAIT_REFILL_GNT,
      WAIT_REFILL_DONE
   } ctrl_state_e;

   // Broadcast from the controller to every way
   typedef struct packed
   {
      logic                       rd;       // Read tag and data of set
      logic                       wr;       // Fill, qualified by wr_sel
      logic                       inv;      // Clear valid bit of set
      icache_addr_pkg::way_oh_t   wr_sel;
      icache_addr_pkg::set_idx_t  set;
      icache_addr_pkg::tag_t      tag;
      icache_addr_pkg::line_t     wdata;
   } way_cmd_t;

   // Registered answer of one way to a read
   typedef struct packed
   {
      logic                       valid;
      logic                       line_valid;
      logic                       hit;
      icache_addr_pkg::line_t     rdata;
   } way_rsp_t;

   // Merged result of all ways
   typedef struct packed
   {
      logic                       done;
      logic                       hit;
      icache_addr_pkg::line_t     hit_line;
      icache_addr_pkg::way_oh_t   victim;   // Way to fill on a miss
   } lookup_t;

endpackage

`default_nettype wire

// File: icache_macros.svh
////////////////////////////////////////////////////////////
// Sizing of the private instruction cache
// One fetch returns one full line; the offset only picks bytes
// ICACHE_NB_SETS must equal 2**ICACHE_SET_W
// ICACHE_NB_WAYS must be at most 16 (4-bit replacement LFSR)
////////////////////////////////////////////////////////////
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// Fetch port
`define ICACHE_ADDR_W     32
`define ICACHE_LINE_W     128

// Organisation
`define ICACHE_NB_WAYS    4
`define ICACHE_NB_SETS    16

// Address fields, LSB first: offset, set, tag
`define ICACHE_OFFSET_W   4
`define ICACHE_SET_W      4
`define ICACHE_TAG_W      (`ICACHE_ADDR_W - `ICACHE_SET_W - `ICACHE_OFFSET_W)

`endif

// File: icache_top.sv
////////////////////////////////////////////////////////////
// Private instruction cache top level
// Starts in bypass; clearing bypass_i flushes and enables it
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module icache_top
(
   input  wire logic                        clk,
   input  wire logic                        rst_n,

   // Fetch port
   input  wire logic                        fetch_req_i,
   input  wire logic [`ICACHE_ADDR_W-1:0]   fetch_addr_i,
   output logic                             fetch_gnt_o,
   output logic                             fetch_rvalid_o,
   output logic [`ICACHE_LINE_W-1:0]        fetch_rdata_o,

   // Refill port
   output logic                             refill_req_o,
   output logic [`ICACHE_ADDR_W-1:0]        refill_addr_o,
   input  wire logic                        refill_gnt_i,
   input  wire logic                        refill_rvalid_i,
   input  wire logic [`ICACHE_LINE_W-1:0]   refill_rdata_i,

   // Control
   input  wire logic                        bypass_i,
   input  wire logic                        flush_i,
   output logic                             bypassed_o,
   output logic                             flushed_o
);

   icache_ctrl_pkg::way_cmd_t                        way_cmd;
   icache_ctrl_pkg::way_rsp_t [`ICACHE_NB_WAYS-1:0]  way_rsp;
   icache_ctrl_pkg::lookup_t                         lookup;

   icache_controller u_controller
   (
      .clk             ( clk             ),
      .rst_n           ( rst_n           ),
      .bypass_i        ( bypass_i        ),
      .flush_i         ( flush_i         ),
      .bypassed_o      ( bypassed_o      ),
      .flushed_o       ( flushed_o       ),
      .fetch_req_i     ( fetch_req_i     ),
      .fetch_addr_i    ( fetch_addr_i    ),
      .fetch_gnt_o     ( fetch_gnt_o     ),
      .fetch_rvalid_o  ( fetch_rvalid_o  ),
      .fetch_rdata_o   ( fetch_rdata_o   ),
      .refill_req_o    ( refill_req_o    ),
      .refill_addr_o   ( refill_addr_o   ),
      .refill_gnt_i    ( refill_gnt_i    ),
      .refill_rvalid_i ( refill_rvalid_i ),
      .refill_rdata_i  ( refill_rdata_i  ),
      .way_cmd_o       ( way_cmd         ),
      .lookup_i        ( lookup          )
   );

   for (genvar g = 0; g < `ICACHE_NB_WAYS; g++)
   begin : g_way
      icache_way u_way
      (
         .clk       ( clk               ),
         .rst_n     ( rst_n             ),
         .way_cmd_i ( way_cmd           ),
         .way_sel_i ( way_cmd.wr_sel[g] ),
         .way_rsp_o ( way_rsp[g]        )
      );
   end

   icache_way_select u_way_select
   (
      .clk       ( clk     ),
      .rst_n     ( rst_n   ),
      .way_rsp_i ( way_rsp ),
      .lookup_o  ( lookup  )
   );

endmodule

`default_nettype wire

// File: icache_way.sv
////////////////////////////////////////////////////////////
// One cache way: valid bits, tag array and data array
// Read result is registered, one cycle after the read strobe
// Write and invalidate act on the next clock edge
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module icache_way
(
   input  wire logic                       clk,
   input  wire logic                       rst_n,

   input  wire icache_ctrl_pkg::way_cmd_t  way_cmd_i,
   input  wire logic                       way_sel_i,   // This way is the fill target
   output icache_ctrl_pkg::way_rsp_t       way_rsp_o
);

   icache_addr_pkg::tag_t   tag_mem  [`ICACHE_NB_SETS];
   icache_addr_pkg::line_t  data_mem [`ICACHE_NB_SETS];
   logic [`ICACHE_NB_SETS-1:0] valid_q;

   logic                    rsp_valid_q;
   logic                    line_valid_q;
   logic                    hit_q;
   icache_addr_pkg::line_t  rdata_q;

   logic                    fill;

   assign fill = way_cmd_i.wr & way_sel_i;

   ////////////////////////////////////////////////////////////
   // Valid bits
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk, negedge rst_n)
   begin
      if (!rst_n)
      begin
         valid_q     <= '0;
         rsp_valid_q <= 1'b0;
      end
      else
      begin
         rsp_valid_q <= way_cmd_i.rd;
         if (way_cmd_i.inv)
            valid_q[way_cmd_i.set] <= 1'b0;
         else if (fill)
            valid_q[way_cmd_i.set] <= 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////
   // Tag and data arrays, read port
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk)
   begin
      if (fill)
      begin
         tag_mem[way_cmd_i.set]  <= way_cmd_i.tag;
         data_mem[way_cmd_i.set] <= way_cmd_i.wdata;
      end
      if (way_cmd_i.rd)
      begin
         line_valid_q <= valid_q[way_cmd_i.set];
         hit_q        <= valid_q[way_cmd_i.set] &&
                         (tag_mem[way_cmd_i.set] == way_cmd_i.tag);
         rdata_q      <= data_mem[way_cmd_i.set];
      end
   end

   assign way_rsp_o.valid      = rsp_valid_q;
   assign way_rsp_o.line_valid = line_valid_q;
   assign way_rsp_o.hit        = hit_q;
   assign way_rsp_o.rdata      = rdata_q;

endmodule

`default_nettype wire

// File: icache_way_select.sv
////////////////////////////////////////////////////////////
// Merges the way responses into hit, hit line and victim
// Victim is the lowest invalid way, else picked by a 4-bit
// Galois LFSR that steps on each miss with all ways valid
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module icache_way_select
(
   input  wire logic                                             clk,
   input  wire logic                                             rst_n,

   input  wire icache_ctrl_pkg::way_rsp_t [`ICACHE_NB_WAYS-1:0]  way_rsp_i,
   output icache_ctrl_pkg::lookup_t                              lookup_o
);

   localparam int WAY_IDX_W = (`ICACHE_NB_WAYS > 1) ? $clog2(`ICACHE_NB_WAYS) : 1;

   logic [3:0]                lfsr_q;
   logic                      done;
   logic                      hit;
   logic                      all_valid;
   icache_addr_pkg::line_t    hit_line;
   icache_addr_pkg::way_oh_t  free_oh;
   icache_addr_pkg::way_oh_t  random_oh;

   ////////////////////////////////////////////////////////////
   // Hit merge and first free way
   ////////////////////////////////////////////////////////////
   always_comb
   begin
      done      = 1'b0;
      hit       = 1'b0;
      all_valid = 1'b1;
      hit_line  = '0;
      free_oh   = '0;
      for (int w = `ICACHE_NB_WAYS - 1; w >= 0; w--)
      begin
         done      = done | way_rsp_i[w].valid;
         hit       = hit | way_rsp_i[w].hit;
         all_valid = all_valid & way_rsp_i[w].line_valid;
         if (way_rsp_i[w].hit)
            hit_line = hit_line | way_rsp_i[w].rdata;   // At most one way hits
         if (!way_rsp_i[w].line_valid)
         begin
            free_oh    = '0;
            free_oh[w] = 1'b1;   // Lowest index wins
         end
      end
   end

   assign random_oh = icache_addr_pkg::way_oh_t'(1) << lfsr_q[WAY_IDX_W-1:0];

   // x^4 + x^3 + 1, shift right
   always_ff @(posedge clk, negedge rst_n)
   begin
      if (!rst_n)
         lfsr_q <= 4'h1;
      else if (done && !hit && all_valid)
         lfsr_q <= (lfsr_q >> 1) ^ ({4{lfsr_q[0]}} & 4'hc);
   end

   assign lookup_o.done     = done;
   assign lookup_o.hit      = hit;
   assign lookup_o.hit_line = hit_line;
   assign lookup_o.victim   = all_valid ? random_oh : free_oh;

endmodule

`default_nettype wire

// File: tb_icache.sv
////////////////////////////////////////////////////////////
// Testbench of the instruction cache
// Refill memory returns a line derived from its address
// Inputs change on the falling edge and checks sample on the rising edge
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module tb_icache;

   localparam time    CLK_PERIOD  = 100ns;
   localparam integer SEED        = 32'hfed578b5;
   localparam int     N_RANDOM    = 160;
   localparam int     STIM_CYCLES = 2 * (N_RANDOM + 40);   // About two per fetch
   localparam logic [`ICACHE_LINE_W-1:0] LINE_KEY =
      128'h5a3c_96e1_0f87_d24b_a5c3_691e_f078_2db4;

   logic                          clk;
   logic                          rst_n;
   logic                          fetch_req_i;
   logic [`ICACHE_ADDR_W-1:0]     fetch_addr_i;
   logic                          fetch_gnt_o;
   logic                          fetch_rvalid_o;
   logic [`ICACHE_LINE_W-1:0]     fetch_rdata_o;
   logic                          refill_req_o;
   logic [`ICACHE_ADDR_W-1:0]     refill_addr_o;
   logic                          refill_gnt_i;
   logic                          refill_rvalid_i;
   logic [`ICACHE_LINE_W-1:0]     refill_rdata_i;
   logic                          bypass_i;
   logic                          flush_i;
   logic                          bypassed_o;
   logic                          flushed_o;

   logic [`ICACHE_ADDR_W-1:0]     exp_q [$];     // Granted fetch addresses in order
   logic                          expect_hit;
   logic                          expect_miss;
   integer                        seed     = SEED;
   integer                        mem_seed = ~SEED;
   int                            data_errors   = 0;
   int                            timing_errors = 0;

   icache_top u_icache_top
   (
      .clk             ( clk             ),
      .rst_n           ( rst_n           ),
      .fetch_req_i     ( fetch_req_i     ),
      .fetch_addr_i    ( fetch_addr_i    ),
      .fetch_gnt_o     ( fetch_gnt_o     ),
      .fetch_rvalid_o  ( fetch_rvalid_o  ),
      .fetch_rdata_o   ( fetch_rdata_o   ),
      .refill_req_o    ( refill_req_o    ),
      .refill_addr_o   ( refill_addr_o   ),
      .refill_gnt_i    ( refill_gnt_i    ),
      .refill_rvalid_i ( refill_rvalid_i ),
      .refill_rdata_i  ( refill_rdata_i  ),
      .bypass_i        ( bypass_i        ),
      .flush_i         ( flush_i         ),
      .bypassed_o      ( bypassed_o      ),
      .flushed_o       ( flushed_o       )
   );

   bind icache_top tb_icache_asserts u_asserts (.*);

   // Memory line is its line address repeated and XORed with a key
   function automatic logic [`ICACHE_LINE_W-1:0] line_data(input logic [`ICACHE_ADDR_W-1:0] addr);
      logic [31:0] line_addr;
      line_addr = addr >> `ICACHE_OFFSET_W;
      return {4{line_addr}} ^ LINE_KEY;
   endfunction

   function automatic int rand_below(inout integer seed_v, input int n);
      return int'($unsigned($random(seed_v)) % n);
   endfunction

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   ////////////////////////////////////////////////////////////
   // Refill memory model
   ////////////////////////////////////////////////////////////
   initial
   begin : refill_model
      int                         delay;
      logic [`ICACHE_ADDR_W-1:0]  line_addr;
      refill_gnt_i    = 1'b0;
      refill_rvalid_i = 1'b0;
      refill_rdata_i  = '0;
      forever
      begin
         @(negedge clk);
         if (rst_n && refill_req_o)
         begin
            delay = rand_below(mem_seed, 4);   // 0 to 3 cycles to the grant
            repeat (delay) @(negedge clk);
            refill_gnt_i = 1'b1;
            line_addr    = refill_addr_o;
            @(negedge clk);
            refill_gnt_i = 1'b0;
            delay = 1 + rand_below(mem_seed, 4);
            repeat (delay - 1) @(negedge clk);
            refill_rvalid_i = 1'b1;
            refill_rdata_i  = line_data(line_addr);
            @(negedge clk);
            refill_rvalid_i = 1'b0;
            refill_rdata_i  = '0;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Response checks
   ////////////////////////////////////////////////////////////
   always @(posedge clk)
   begin : data_check
      logic [`ICACHE_LINE_W-1:0] exp_line;
      if (rst_n)
      begin
         if (fetch_rvalid_o && exp_q.size() == 0)
         begin
            $display("%0t: fetch_rvalid_o high with no fetch outstanding", $time);
            data_errors++;
         end
         else if (fetch_rvalid_o)
         begin
            exp_line = line_data(exp_q.pop_front());
            assert (fetch_rdata_o === exp_line)
            else
            begin
               $display("** Error @ %0t: fetch_rdata_o = %h, expected %h",
                        $time, fetch_rdata_o, exp_line);
               data_errors++;
            end
         end
         if (fetch_req_i && fetch_gnt_o)
            exp_q.push_back(fetch_addr_i);   // Pushed after the pop as a same-cycle rvalid is older
      end
   end

   hit_in_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      expect_hit && fetch_req_i && fetch_gnt_o |=> fetch_rvalid_o && !refill_req_o)
   else
   begin
      $display("%0t: a fetch of a cached line did not hit in the next cycle", $time);
      timing_errors++;
   end

   miss_refills: assert property (@(posedge clk) disable iff (!rst_n)
      expect_miss && fetch_req_i && fetch_gnt_o |=> refill_req_o)
   else
   begin
      $display("%0t: a fetch of an uncached line raised no refill request", $time);
      timing_errors++;
   end

   // A fetch is granted in bypass only while bypass is requested
   bypass_mode: assert property (@(posedge clk) disable iff (!rst_n)
      fetch_req_i && fetch_gnt_o |-> bypassed_o == bypass_i)
   else
   begin
      $display("** Error @ %0t: bypassed_o = %b, expected %b",
               $time, $sampled(bypassed_o), $sampled(bypass_i));
      data_errors++;
   end

   ////////////////////////////////////////////////////////////
   // Fetch tasks
   ////////////////////////////////////////////////////////////
   task automatic wait_grant;
      do @(posedge clk); while (!fetch_gnt_o);
      @(negedge clk);
   endtask

   task automatic drain_fetches;
      while (exp_q.size() != 0) @(negedge clk);
   endtask

   task automatic fetch_line(input logic [`ICACHE_ADDR_W-1:0] addr);
      fetch_req_i  = 1'b1;
      fetch_addr_i = addr;
      wait_grant();
      fetch_req_i  = 1'b0;
      drain_fetches();
   endtask

   // Request stays high with a new address after every grant
   task automatic fetch_burst(input logic [`ICACHE_ADDR_W-1:0] addrs [$]);
      foreach (addrs[i])
      begin
         fetch_req_i  = 1'b1;
         fetch_addr_i = addrs[i];
         wait_grant();
      end
      fetch_req_i = 1'b0;
      drain_fetches();
   endtask

   initial
   begin : watchdog
      #((STIM_CYCLES * 10 + 1000) * CLK_PERIOD);
      $display("Watchdog expired, the DUT stopped answering fetches");
      $display("*** TEST FAILED ***");
      $finish;
   end

   ////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////
   initial
   begin : stimulus
      logic [`ICACHE_ADDR_W-1:0] addr;
      logic [`ICACHE_ADDR_W-1:0] burst [$];
      int                        total;
      rst_n        = 1'b0;
      fetch_req_i  = 1'b0;
      fetch_addr_i = '0;
      bypass_i     = 1'b1;
      flush_i      = 1'b0;
      expect_hit   = 1'b0;
      expect_miss  = 1'b0;
      repeat (8) @(negedge clk);
      rst_n = 1'b1;
      repeat (2) @(negedge clk);

      // Bypass mode sends every fetch to the refill port
      fetch_line(32'h0000_1000);
      fetch_line(32'h0000_2014);
      burst = '{32'h0000_3000, 32'h0000_3010, 32'h0000_3020};
      fetch_burst(burst);

      // Bypass drops while the last bypassed refill is still out
      fetch_req_i  = 1'b1;
      fetch_addr_i = 32'h0000_4000;
      wait_grant();
      bypass_i     = 1'b0;

      // First cached grant waits for that refill and for the flush
      expect_miss = 1'b1;
      fetch_line(32'h0001_0040);
      fetch_line(32'h0001_0050);
      fetch_line(32'h0001_0060);
      expect_miss = 1'b0;
      expect_hit  = 1'b1;
      fetch_line(32'h0001_0048);
      burst = '{32'h0001_0040, 32'h0001_0050, 32'h0001_0060, 32'h0001_0044};
      fetch_burst(burst);
      expect_hit  = 1'b0;

      // Six lines into one set and then the first one again
      expect_miss = 1'b1;
      for (int t = 0; t < 6; t++)
         fetch_line({24'h000200 + 24'(t), 4'd3, 4'h0});
      expect_miss = 1'b0;
      fetch_line({24'h000200, 4'd3, 4'h8});

      for (int i = 0; i < N_RANDOM; i++)
      begin
         addr[31:8] = 24'h000300 + 24'(rand_below(seed, 6));
         addr[7:4]  = rand_below(seed, 2) ? 4'd9 : 4'd12;
         addr[3:0]  = 4'(rand_below(seed, 16));
         fetch_line(addr);
         repeat (rand_below(seed, 3)) @(negedge clk);
      end

      // Flush request drops a cached line
      fetch_line(32'h0004_0070);
      expect_hit = 1'b1;
      fetch_line(32'h0004_0074);
      expect_hit = 1'b0;
      flush_i = 1'b1;
      @(negedge clk);
      flush_i = 1'b0;
      do @(posedge clk); while (!flushed_o);
      @(negedge clk);
      expect_miss = 1'b1;
      fetch_line(32'h0004_0070);
      expect_miss = 1'b0;

      repeat (5) @(negedge clk);
      if (exp_q.size() != 0)
      begin
         $display("%0d granted fetches never returned data", exp_q.size());
         data_errors++;
      end
      total = data_errors + timing_errors + u_icache_top.u_asserts.fail_cnt;
      $display("Checks done: %0d data errors, %0d timing errors, %0d protocol errors",
               data_errors, timing_errors, u_icache_top.u_asserts.fail_cnt);
      if (total == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

// File: tb_icache_asserts.sv
////////////////////////////////////////////////////////////
// Port protocol and timing checks of the instruction cache
// Bound into icache_top
// fail_cnt counts the failed checks
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module tb_icache_asserts
(
   input wire logic                       clk,
   input wire logic                       rst_n,
   input wire logic                       fetch_req_i,
   input wire logic [`ICACHE_ADDR_W-1:0]  fetch_addr_i,
   input wire logic                       fetch_gnt_o,
   input wire logic                       fetch_rvalid_o,
   input wire logic                       refill_req_o,
   input wire logic [`ICACHE_ADDR_W-1:0]  refill_addr_o,
   input wire logic                       refill_gnt_i,
   input wire logic                       refill_rvalid_i,
   input wire logic                       bypassed_o,
   input wire logic                       flushed_o
);

   int    fail_cnt = 0;
   logic  refill_busy_q;     // Refill granted and its data not yet back
   int    fetch_pend_q;

   always_ff @(posedge clk, negedge rst_n)
   begin
      if (!rst_n)
      begin
         refill_busy_q <= 1'b0;
         fetch_pend_q  <= 0;
      end
      else
      begin
         if (refill_req_o && refill_gnt_i)
            refill_busy_q <= 1'b1;
         else if (refill_rvalid_i)
            refill_busy_q <= 1'b0;
         fetch_pend_q <= fetch_pend_q + int'(fetch_req_i && fetch_gnt_o)
                         - int'(fetch_rvalid_o);
      end
   end

   ////////////////////////////////////////////////////////////
   // Refill port
   ////////////////////////////////////////////////////////////
   refill_hold: assert property (@(posedge clk) disable iff (!rst_n)
      refill_req_o && !refill_gnt_i |=> refill_req_o && $stable(refill_addr_o))
   else
   begin
      $error("refill request dropped or its address moved before the grant");
      fail_cnt++;
   end

   one_refill: assert property (@(posedge clk) disable iff (!rst_n)
      refill_req_o |-> !refill_busy_q)
   else
   begin
      $error("second refill requested while one is outstanding");
      fail_cnt++;
   end

   ////////////////////////////////////////////////////////////
   // Fetch port and bypass
   ////////////////////////////////////////////////////////////
   gnt_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
      fetch_gnt_o |-> fetch_req_i)
   else
   begin
      $error("fetch granted without a request");
      fail_cnt++;
   end

   rvalid_pending: assert property (@(posedge clk) disable iff (!rst_n)
      fetch_rvalid_o |-> fetch_pend_q > 0)
   else
   begin
      $error("fetch response without a granted fetch");
      fail_cnt++;
   end

   bypass_refill: assert property (@(posedge clk) disable iff (!rst_n)
      bypassed_o && fetch_req_i && fetch_gnt_o
      |=> refill_req_o && refill_addr_o == $past(fetch_addr_i))
   else
   begin
      $error("bypassed fetch not forwarded to the refill port");
      fail_cnt++;
   end

   // Leaving bypass starts a flush of every set
   flush_length: assert property (@(posedge clk) disable iff (!rst_n)
      $fell(bypassed_o)
      |-> (!fetch_gnt_o && !flushed_o) [*`ICACHE_NB_SETS - 1] ##1 (!fetch_gnt_o && flushed_o))
   else
   begin
      $error("flush did not last one cycle per set");
      fail_cnt++;
   end

   flushed_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      flushed_o |=> !flushed_o)
   else
   begin
      $error("flushed_o high for more than one cycle");
      fail_cnt++;
   end

endmodule

`default_nettype wire
